/* include/drive_macros.svh */
`ifndef DRIVE_MACROS_SVH
`define DRIVE_MACROS_SVH

//////////////////////////////
// Tick divisors
//////////////////////////////

// Fast tick at 100 Hz from a 65 MHz clock
`define DRIVE_FAST_DIV 650000
// Slow tick at 10 Hz
`define DRIVE_SLOW_DIV 6500000

//////////////////////////////
// Engine model
//////////////////////////////

`define DRIVE_RPM_IDLE 800
`define DRIVE_RPM_MAX 9000
`define DRIVE_RPM_REDLINE 7500

// Change per fast tick
`define DRIVE_RPM_UP 150
`define DRIVE_RPM_DOWN 100

// Rpm scaling before the gear factor
`define DRIVE_STEP_SHIFT 7

`endif

/* logic/drive_pkg.sv */
`default_nettype none

package drive_pkg;

    // 0 is neutral, 1 to 3 drive
    typedef logic [1:0] gear_t;

    typedef logic [13:0] rpm_t;

    typedef logic [6:0] step_t;

    // Wraps on overflow
    typedef logic [31:0] position_t;

    //////////////////////////////
    // Stage payloads
    //////////////////////////////

    typedef struct packed {
        logic press_tick;
        logic held;
    } key_t;

    // Gear shifter output
    typedef struct packed {
        gear_t gear;
        logic  gas;
    } drive_cmd_t;

    // Engine model output
    typedef struct packed {
        gear_t gear;
        rpm_t  rpm;
        logic  redline;
    } engine_t;

endpackage

`default_nettype wire

/* logic/tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
    parameter int unsigned DIVISOR = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic clear,
    output logic tick
);

    localparam int unsigned CNT_W = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DIVISOR - 1);

    logic [CNT_W-1:0] count;

    // One cycle pulse on the last count
    assign tick = (count == LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear || tick) begin
            // Restart keeps ticks aligned with a new game
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/gear_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module gear_shifter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clear,
    input  drive_pkg::key_t        keys,
    input  logic                   controller_en,
    output drive_pkg::drive_cmd_t  cmd
);

    import drive_pkg::*;

    logic press;
    logic throttle;

    // Keys only count while the controller is enabled
    assign press    = keys.press_tick & controller_en;
    assign throttle = keys.held & controller_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd <= '0;
        end else if (clear) begin
            cmd <= '0;
        end else begin
            // Gear order 0 1 2 3 then back to neutral
            if (press) begin
                cmd.gear <= cmd.gear + gear_t'(1);
            end
            cmd.gas <= throttle;
        end
    end

endmodule

`default_nettype wire

/* logic/engine_rpm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "drive_macros.svh"

module engine_rpm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clear,
    input  logic                   fast_tick,
    input  drive_pkg::drive_cmd_t  cmd,
    output drive_pkg::engine_t     eng
);

    import drive_pkg::*;

    localparam rpm_t RPM_IDLE    = rpm_t'(`DRIVE_RPM_IDLE);
    localparam rpm_t RPM_MAX     = rpm_t'(`DRIVE_RPM_MAX);
    localparam rpm_t RPM_REDLINE = rpm_t'(`DRIVE_RPM_REDLINE);
    localparam rpm_t RPM_UP      = rpm_t'(`DRIVE_RPM_UP);
    localparam rpm_t RPM_DOWN    = rpm_t'(`DRIVE_RPM_DOWN);

    localparam engine_t ENG_RESET = '{gear: '0, rpm: RPM_IDLE, redline: 1'b0};

    // Spare top bit so the sum cannot wrap
    logic [14:0] rpm_up;
    rpm_t        rpm_next;

    //////////////////////////////
    // Next rpm
    //////////////////////////////

    always_comb begin
        rpm_up = {1'b0, eng.rpm} + {1'b0, RPM_UP};
        if (cmd.gas) begin
            if (rpm_up >= {1'b0, RPM_MAX}) begin
                rpm_next = RPM_MAX;
            end else begin
                rpm_next = rpm_up[13:0];
            end
        end else if (eng.rpm < RPM_IDLE + RPM_DOWN) begin
            // Engine settles at idle
            rpm_next = RPM_IDLE;
        end else begin
            rpm_next = eng.rpm - RPM_DOWN;
        end
    end

    //////////////////////////////
    // Engine state
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eng <= ENG_RESET;
        end else if (clear) begin
            eng <= ENG_RESET;
        end else if (fast_tick) begin
            eng.gear    <= cmd.gear;
            eng.rpm     <= rpm_next;
            eng.redline <= (rpm_next >= RPM_REDLINE);
        end
    end

endmodule

`default_nettype wire

/* logic/rpm_to_step.sv */
`timescale 1ns/1ps
`default_nettype none

`include "drive_macros.svh"

module rpm_to_step (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear,
    input  logic                fast_tick,
    input  drive_pkg::engine_t  eng,
    output drive_pkg::step_t    step
);

    import drive_pkg::*;

    localparam logic [15:0] STEP_LIMIT = 16'd127;

    rpm_t        rpm_scaled;
    logic [15:0] product;

    // Neutral multiplies to zero
    assign rpm_scaled = eng.rpm >> `DRIVE_STEP_SHIFT;
    assign product    = 16'(rpm_scaled) * 16'(eng.gear);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= '0;
        end else if (clear) begin
            step <= '0;
        end else if (fast_tick) begin
            // Clamp to the widest step
            if (product > STEP_LIMIT) begin
                step <= step_t'(STEP_LIMIT);
            end else begin
                step <= product[6:0];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/position_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module position_adder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clear,
    input  logic                  slow_tick,
    input  drive_pkg::step_t      step,
    output drive_pkg::position_t  position
);

    import drive_pkg::*;

    position_t step_ext;

    assign step_ext = position_t'(step);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            position <= '0;
        end else if (clear) begin
            position <= '0;
        end else if (slow_tick) begin
            // Wraps at 2**32
            position <= position + step_ext;
        end
    end

endmodule

`default_nettype wire

/* logic/drive_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "drive_macros.svh"

module drive_top #(
    parameter int unsigned FAST_DIV = `DRIVE_FAST_DIV,
    parameter int unsigned SLOW_DIV = `DRIVE_SLOW_DIV
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  drive_pkg::key_t       keys,
    input  logic                  controller_en,
    input  logic                  clear,
    output drive_pkg::position_t  position,
    output drive_pkg::gear_t      gear,
    output logic                  redline,
    output logic                  slow_tick
);

    import drive_pkg::*;

    logic       fast_tick;
    drive_cmd_t cmd;
    engine_t    eng;
    step_t      step;

    //////////////////////////////
    // Enable ticks
    //////////////////////////////

    tick_gen #(.DIVISOR(FAST_DIV)) u_fast_tick (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (clear),
        .tick  (fast_tick)
    );

    tick_gen #(.DIVISOR(SLOW_DIV)) u_slow_tick (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (clear),
        .tick  (slow_tick)
    );

    //////////////////////////////
    // Pipeline stages
    //////////////////////////////

    gear_shifter u_gear_shifter (
        .clk           (clk),
        .rst_n         (rst_n),
        .clear         (clear),
        .keys          (keys),
        .controller_en (controller_en),
        .cmd           (cmd)
    );

    engine_rpm u_engine_rpm (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .fast_tick (fast_tick),
        .cmd       (cmd),
        .eng       (eng)
    );

    rpm_to_step u_rpm_to_step (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .fast_tick (fast_tick),
        .eng       (eng),
        .step      (step)
    );

    position_adder u_position_adder (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .slow_tick (slow_tick),
        .step      (step),
        .position  (position)
    );

    // Cockpit outputs
    assign gear    = cmd.gear;
    assign redline = eng.redline;

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD = 50
) (
    output logic clk
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

/* bench/drive_props.sv */
`timescale 1ns/1ps
`default_nettype none

`include "drive_macros.svh"

module drive_props (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clear,
    input  logic                  fast_tick,
    input  logic                  slow_tick,
    input  drive_pkg::engine_t    eng,
    input  drive_pkg::position_t  position
);

    import drive_pkg::*;

    //////////////////////////////
    // Tick shape
    //////////////////////////////

    fast_tick_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        fast_tick |=> !fast_tick)
        else $error("fast_tick stayed high for more than one cycle");

    slow_tick_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        slow_tick |=> !slow_tick)
        else $error("slow_tick stayed high for more than one cycle");

    //////////////////////////////
    // Engine and position
    //////////////////////////////

    rpm_range: assert property (@(posedge clk) disable iff (!rst_n)
        (eng.rpm >= rpm_t'(`DRIVE_RPM_IDLE)) && (eng.rpm <= rpm_t'(`DRIVE_RPM_MAX)))
        else $error("engine rpm left the idle to ceiling range");

    // Only a slow tick or a restart moves the position
    position_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (position != $past(position)) |-> ($past(slow_tick) || $past(clear)))
        else $error("position changed without a slow tick");

endmodule

bind drive_top drive_props u_drive_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .fast_tick (fast_tick),
    .slow_tick (slow_tick),
    .eng       (eng),
    .position  (position)
);

`default_nettype wire

/* bench/drive_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "drive_macros.svh"

module drive_tb;

    import drive_pkg::*;

    localparam int FAST_DIV       = 4;
    localparam int SLOW_DIV       = 40;
    localparam int TIMEOUT_CYCLES = 3000;

    // One field per pipeline register
    typedef struct packed {
        int        fast_cnt;
        int        slow_cnt;
        gear_t     gear;
        logic      gas;
        gear_t     eng_gear;
        rpm_t      rpm;
        logic      redline;
        step_t     step;
        position_t position;
    } model_t;

    localparam model_t MODEL_RESET = '{fast_cnt: 0, slow_cnt: 0, gear: '0, gas: 1'b0,
        eng_gear: '0, rpm: rpm_t'(`DRIVE_RPM_IDLE), redline: 1'b0, step: '0, position: '0};

    logic      clk;
    logic      rst_n;
    key_t      keys;
    logic      controller_en;
    logic      clear;
    position_t position;
    gear_t     gear;
    logic      redline;
    logic      slow_tick;
    model_t    model = MODEL_RESET;
    string     test_name = "reset";
    int        cycles = 0;

    tb_clock u_tb_clock (.clk(clk));

    drive_top #(.FAST_DIV(FAST_DIV), .SLOW_DIV(SLOW_DIV)) u_drive_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .keys          (keys),
        .controller_en (controller_en),
        .clear         (clear),
        .position      (position),
        .gear          (gear),
        .redline       (redline),
        .slow_tick     (slow_tick)
    );

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic model_t step_model(model_t s, key_t k, logic en, logic clr);
        model_t n;
        logic   fast;
        logic   slow;
        int     r;
        int     p;
        n = s;
        fast = (s.fast_cnt == FAST_DIV - 1);
        slow = (s.slow_cnt == SLOW_DIV - 1);
        if (clr) begin
            n = MODEL_RESET;
        end else begin
            n.fast_cnt = fast ? 0 : s.fast_cnt + 1;
            n.slow_cnt = slow ? 0 : s.slow_cnt + 1;
            if (k.press_tick && en) begin
                n.gear = s.gear + gear_t'(1);
            end
            n.gas = k.held && en;
            if (fast) begin
                // Engine and converter both use the values held before the tick
                if (s.gas) begin
                    r = int'(s.rpm) + `DRIVE_RPM_UP;
                    r = (r > `DRIVE_RPM_MAX) ? `DRIVE_RPM_MAX : r;
                end else begin
                    r = int'(s.rpm) - `DRIVE_RPM_DOWN;
                    r = (r < `DRIVE_RPM_IDLE) ? `DRIVE_RPM_IDLE : r;
                end
                n.rpm = rpm_t'(r);
                n.eng_gear = s.gear;
                n.redline = (r >= `DRIVE_RPM_REDLINE);
                p = (int'(s.rpm) >> `DRIVE_STEP_SHIFT) * int'(s.eng_gear);
                n.step = step_t'((p > 127) ? 127 : p);
            end
            if (slow) begin
                n.position = s.position + position_t'(s.step);
            end
        end
        return n;
    endfunction

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic position_check(string name, position_t exp, position_t act);
        if (act !== exp) begin
            $display("Mismatch in %s: position expected %0d, actual %0d", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic gear_check(string name, gear_t exp, gear_t act);
        if (act !== exp) begin
            $display("Mismatch in %s: gear expected %0d, actual %0d", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic flag_check(string name, string what, logic exp, logic act);
        if (act !== exp) begin
            $display("Mismatch in %s: %s expected %b, actual %b", name, what, exp, act);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // Model steps on the same edge as the DUT
    always @(posedge clk) begin
        if (!rst_n) begin
            model = MODEL_RESET;
        end else begin
            model = step_model(model, keys, controller_en, clear);
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            gear_check(test_name, model.gear, gear);
            flag_check(test_name, "redline", model.redline, redline);
            flag_check(test_name, "slow_tick", model.slow_cnt == SLOW_DIV - 1, slow_tick);
            position_check(test_name, model.position, position);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the script did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic hold_for(int n);
        repeat (n) next_cycle();
    endtask

    task automatic press_key();
        keys.press_tick = 1'b1;
        next_cycle();
        keys.press_tick = 1'b0;
    endtask

    initial begin
        void'($urandom(9));
        rst_n = 1'b0;
        keys = '0;
        controller_en = 1'b0;
        clear = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        hold_for(2);
        gear_check(test_name, '0, gear);
        position_check(test_name, '0, position);
        flag_check(test_name, "redline", 1'b0, redline);

        test_name = "gear_cycle";
        controller_en = 1'b1;
        for (int i = 1; i <= 4; i++) begin
            press_key();
            gear_check(test_name, gear_t'(i), gear);
            hold_for(1 + int'($urandom % 4));
        end

        // Keys ignored while the controller is off
        test_name = "gating";
        controller_en = 1'b0;
        keys.held = 1'b1;
        repeat (3) begin
            press_key();
            hold_for(2 + int'($urandom % 3));
        end
        gear_check(test_name, '0, gear);

        test_name = "neutral_throttle";
        controller_en = 1'b1;
        keys.held = 1'b1;
        hold_for(240 + int'($urandom % 20));
        flag_check(test_name, "redline", 1'b1, redline);
        position_check(test_name, '0, position);

        test_name = "driving";
        for (int g = 1; g <= 3; g++) begin
            press_key();
            hold_for(150 + int'($urandom % 50));
            keys.held = 1'b0;
            hold_for(10 + int'($urandom % 10));
            keys.held = 1'b1;
            hold_for(20);
        end

        test_name = "release";
        keys.held = 1'b0;
        hold_for(100 + int'($urandom % 10));
        flag_check(test_name, "redline", 1'b0, redline);

        test_name = "clear";
        keys.held = 1'b1;
        hold_for(20 + int'($urandom % 8));
        clear = 1'b1;
        next_cycle();
        clear = 1'b0;
        gear_check(test_name, '0, gear);
        position_check(test_name, '0, position);
        flag_check(test_name, "redline", 1'b0, redline);
        flag_check(test_name, "slow_tick", 1'b0, slow_tick);

        // Ticks restart from zero after clear
        test_name = "after_clear";
        press_key();
        press_key();
        hold_for(3 * SLOW_DIV);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
logic/drive_pkg.sv
logic/tick_gen.sv
logic/gear_shifter.sv
logic/engine_rpm.sv
logic/rpm_to_step.sv
logic/position_adder.sv
logic/drive_top.sv
bench/tb_clock.sv
bench/drive_props.sv
bench/drive_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the drive train testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module drive_tb -f sources.f -o drive_sim

status=0
./obj_dir/drive_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "Testbench reported a failure, see sim.log"
    exit 1
fi

exit 0
